/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build and run, a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* rv_core.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] insn,
  output logic [`RV_XLEN-1:0] pc,
  output logic                retire_valid,
  output rv_pkg::retire_t     retire,
  output logic                halt,
  output logic                illegal
);

  rv_pkg::decoded_t    dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] wdata;
  logic                branch_taken;
  logic                reg_we;

  rv_fetch rv_fetch_inst (
    .clk          (clk),
    .rst          (rst),
    .imm          (dec.imm),
    .is_branch    (dec.is_branch),
    .branch_taken (branch_taken),
    .halted       (halt),
    .pc           (pc)
  );

  rv_decode rv_decode_inst (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .we       (reg_we),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute rv_execute_inst (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wdata        (wdata),
    .branch_taken (branch_taken)
  );

  rv_retire rv_retire_inst (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .dec          (dec),
    .wdata        (wdata),
    .reg_we       (reg_we),
    .halted       (halt),
    .retire_valid (retire_valid),
    .retire       (retire),
    .illegal      (illegal)
  );

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0] insn,
  output rv_pkg::decoded_t    dec
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates, sign-extended to a full word
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec           = '0;
    dec.rs1       = insn[19:15];
    dec.rs2       = insn[24:20];
    dec.rd        = insn[11:7];
    dec.imm       = imm_i;
    dec.alu_op    = rv_pkg::alu_add;
    dec.br_funct3 = funct3;

    case (opcode)
      rv_pkg::op_lui: begin
        dec.imm       = imm_u;
        dec.alu_op    = rv_pkg::alu_pass_imm;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_pkg::op_reg_imm: begin
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = rv_pkg::alu_add;
          3'b010: dec.alu_op = rv_pkg::alu_slt;
          3'b011: dec.alu_op = rv_pkg::alu_sltu;
          3'b100: dec.alu_op = rv_pkg::alu_xor;
          3'b110: dec.alu_op = rv_pkg::alu_or;
          3'b111: dec.alu_op = rv_pkg::alu_and;
          3'b001: begin
            dec.alu_op  = rv_pkg::alu_sll;
            dec.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // srli and srai share funct3, told apart by funct7
            if (funct7 == 7'b0000000) begin
              dec.alu_op = rv_pkg::alu_srl;
            end else if (funct7 == 7'b0100000) begin
              dec.alu_op = rv_pkg::alu_sra;
            end else begin
              dec.illegal = 1'b1;
            end
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        // only add is kept
        dec.reg_write = 1'b1;
        dec.illegal   = (funct3 != 3'b000) || (funct7 != 7'b0000000);
      end
      rv_pkg::op_branch: begin
        dec.imm = imm_b;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          dec.illegal = 1'b1;
        end else begin
          dec.is_branch = 1'b1;
        end
      end
      rv_pkg::op_system: begin
        if (insn[31:7] == 25'd0) begin
          dec.is_ecall = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // an illegal encoding never writes a register
    if (dec.illegal) begin
      dec.reg_write = 1'b0;
    end
  end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
  input  rv_pkg::decoded_t    dec,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] wdata,
  output logic                branch_taken
);

  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                lt_signed;
  logic                lt_unsigned;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_pass_imm: wdata = dec.imm;
      rv_pkg::alu_add:      wdata = rs1_data + op_b;
      rv_pkg::alu_slt:      wdata = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu:     wdata = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor:      wdata = rs1_data ^ op_b;
      rv_pkg::alu_or:       wdata = rs1_data | op_b;
      rv_pkg::alu_and:      wdata = rs1_data & op_b;
      rv_pkg::alu_sll:      wdata = rs1_data << shamt;
      rv_pkg::alu_srl:      wdata = rs1_data >> shamt;
      rv_pkg::alu_sra:      wdata = $signed(rs1_data) >>> shamt;
      default:              wdata = '0;
    endcase
  end

  // condition on funct3, fetch qualifies it with is_branch
  always_comb begin
    case (dec.br_funct3)
      3'b000:  branch_taken = (rs1_data == rs2_data);
      3'b001:  branch_taken = (rs1_data != rs2_data);
      3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  branch_taken = rs1_data < rs2_data;
      3'b111:  branch_taken = rs1_data >= rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic                is_branch,
  input  logic                branch_taken,
  input  logic                halted,
  output logic [`RV_XLEN-1:0] pc
);

  logic [`RV_XLEN-1:0] pc_next;

  // sequential step or pc-relative branch target
  always_comb begin
    if (is_branch && branch_taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + `RV_INSN_STEP;
    end
  end

  // pc freezes once the core has halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (!halted) begin
      pc <= pc_next;
    end
  end

endmodule

/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// register and data width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// program counter
`define RV_RESET_PC 32'h0000_0000
`define RV_INSN_STEP 32'd4

`endif

/* rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

  // major opcodes of the kept instruction groups
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_branch  = 7'b1100011,
    op_system  = 7'b1110011
  } opcode_e;

  // alu operations
  typedef enum logic [3:0] {
    alu_pass_imm,
    alu_add,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  // one decoded instruction
  typedef struct packed {
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm;
    alu_op_e                   alu_op;
    logic                      use_imm;
    logic                      reg_write;
    logic                      is_branch;
    logic [2:0]                br_funct3;
    logic                      is_ecall;
    logic                      illegal;
  } decoded_t;

  // record of one completed instruction
  typedef struct packed {
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       wdata;
    logic                      reg_write;
  } retire_t;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic                      we,
  input  logic [`RV_XLEN-1:0]       wdata,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // asynchronous reads
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rv_retire.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_retire (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] pc,
  input  rv_pkg::decoded_t    dec,
  input  logic [`RV_XLEN-1:0] wdata,
  output logic                reg_we,
  output logic                halted,
  output logic                retire_valid,
  output rv_pkg::retire_t     retire,
  output logic                illegal
);

  // no register writes after halt
  assign reg_we = dec.reg_write && !halted;

  // halt and illegal are sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted       <= 1'b0;
      illegal      <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= !halted;
      if (!halted) begin
        halted  <= dec.is_ecall || dec.illegal;
        illegal <= dec.illegal;
      end
    end
  end

  // retire record of the instruction completing at this edge
  always_ff @(posedge clk) begin
    if (!halted) begin
      retire.pc        <= pc;
      retire.rd        <= dec.rd;
      retire.wdata     <= wdata;
      retire.reg_write <= dec.reg_write;
    end
  end

endmodule

/* sim.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core;

  localparam int PROG_LEN  = 200;
  localparam int MEM_WORDS = 256;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] insn;
  logic [`RV_XLEN-1:0] pc;
  logic                retire_valid;
  rv_pkg::retire_t     retire;
  logic                halt;
  logic                illegal;

  logic [31:0]     imem [MEM_WORDS];
  logic [31:0]     ref_regs [`RV_NUM_REGS];
  logic [31:0]     ref_pc;
  logic            ref_halt;
  logic [31:0]     lfsr_state;
  rv_pkg::retire_t exp_ret;

  rv_core rv_core_inst (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halt         (halt),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // instruction memory answers the fetch address
  initial begin
    insn = '0;
    forever begin
      @(posedge clk);
      #1;
      insn = imem[pc[9:2]];
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, want));
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      val = {val[30:0], b};
    end
    return val;
  endfunction

  // steps the model state by one instruction
  function automatic rv_pkg::retire_t ref_step(input logic [31:0] w);
    rv_pkg::retire_t r;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm_i;
    logic [31:0]     next_pc;
    logic [4:0]      sh;
    logic            bad;
    logic            taken;
    a = ref_regs[w[19:15]];
    b = ref_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    sh = w[24:20];
    r = '0;
    r.pc = ref_pc;
    r.rd = w[11:7];
    r.reg_write = 1'b1;
    bad = 1'b0;
    taken = 1'b0;
    case (w[6:0])
      7'b0110111: r.wdata = {w[31:12], 12'h000};
      7'b0010011: begin
        case (w[14:12])
          3'd0: r.wdata = a + imm_i;
          3'd1: begin
            bad = (w[31:25] != 7'd0);
            r.wdata = a << sh;
          end
          3'd2: r.wdata = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
          3'd3: r.wdata = (a < imm_i) ? 32'd1 : 32'd0;
          3'd4: r.wdata = a ^ imm_i;
          3'd6: r.wdata = a | imm_i;
          3'd7: r.wdata = a & imm_i;
          default: begin
            bad = (w[31:25] != 7'd0) && (w[31:25] != 7'h20);
            if (w[31:25] == 7'h20) begin
              r.wdata = $signed(a) >>> sh;
            end else begin
              r.wdata = a >> sh;
            end
          end
        endcase
      end
      7'b0110011: begin
        bad = (w[14:12] != 3'd0) || (w[31:25] != 7'd0);
        r.wdata = a + b;
      end
      7'b1100011: begin
        r.reg_write = 1'b0;
        case (w[14:12])
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: bad = 1'b1;
        endcase
      end
      7'b1110011: begin
        r.reg_write = 1'b0;
        bad = (w[31:7] != 25'd0);
        ref_halt = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    next_pc = taken ? ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0} : ref_pc + 32'd4;
    if (bad) begin
      r.reg_write = 1'b0;
      ref_halt = 1'b1;
    end
    if (r.reg_write && r.rd != 5'd0) begin
      ref_regs[r.rd] = r.wdata;
    end
    ref_pc = next_pc;
    return r;
  endfunction

  // random program whose last word is ecall
  task automatic gen_program(input int illegal_at);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [12:0] off;
    int          limit;
    int          k;
    for (int a = 0; a < MEM_WORDS; a++) begin
      // fill words carry opcode zero so a stray fetch is illegal
      imem[a[7:0]] = {a[24:0], 7'b0000000};
    end
    for (int idx = 0; idx < PROG_LEN - 1; idx++) begin
      r = rand_bits(3);
      rd = {2'b00, r[2:0]};
      r = rand_bits(3);
      rs1 = {2'b00, r[2:0]};
      r = rand_bits(3);
      rs2 = {2'b00, r[2:0]};
      r = rand_bits(12);
      imm = r[11:0];
      // branches never jump past limit
      limit = (illegal_at > idx) ? illegal_at : PROG_LEN - 1;
      r = rand_bits(4);
      case (r[3:0])
        4'd0: begin
          r = rand_bits(20);
          imem[idx[7:0]] = {r[19:0], rd, 7'b0110111};
        end
        4'd1: imem[idx[7:0]] = {imm, rs1, 3'd0, rd, 7'b0010011};
        4'd2: imem[idx[7:0]] = {imm, rs1, 3'd2, rd, 7'b0010011};
        4'd3: imem[idx[7:0]] = {imm, rs1, 3'd3, rd, 7'b0010011};
        4'd4: imem[idx[7:0]] = {imm, rs1, 3'd4, rd, 7'b0010011};
        4'd5: imem[idx[7:0]] = {imm, rs1, 3'd6, rd, 7'b0010011};
        4'd6: imem[idx[7:0]] = {imm, rs1, 3'd7, rd, 7'b0010011};
        4'd7: imem[idx[7:0]] = {7'h00, imm[4:0], rs1, 3'd1, rd, 7'b0010011};
        4'd8: imem[idx[7:0]] = {7'h00, imm[4:0], rs1, 3'd5, rd, 7'b0010011};
        4'd9: imem[idx[7:0]] = {7'h20, imm[4:0], rs1, 3'd5, rd, 7'b0010011};
        4'd10, 4'd11: imem[idx[7:0]] = {7'h00, rs2, rs1, 3'd0, rd, 7'b0110011};
        default: begin
          r = rand_bits(3);
          f3 = (r[2:1] == 2'b01) ? {2'b00, r[0]} : r[2:0];
          r = rand_bits(2);
          k = 1 + int'(r[1:0]);
          if (idx + k > limit) begin
            k = limit - idx;
          end
          off = 13'(k * 4);
          imem[idx[7:0]] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        end
      endcase
    end
    imem[PROG_LEN - 1] = 32'h0000_0073;
    if (illegal_at >= 0) begin
      // slli with a nonzero funct7
      imem[illegal_at[7:0]] = {7'h01, 5'd3, 5'd2, 3'd1, 5'd1, 7'b0010011};
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    ref_pc = `RV_RESET_PC;
    ref_halt = 1'b0;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      ref_regs[i[4:0]] = '0;
    end
    rst = 1'b0;
    check_val("halt", 32'(halt), 32'd0);
    check_val("illegal", 32'(illegal), 32'd0);
    check_val("retire_valid", 32'(retire_valid), 32'd0);
    check_val("pc", pc, `RV_RESET_PC);
  endtask

  task automatic run_to_halt(input logic exp_illegal);
    int cycles;
    cycles = 0;
    while (!halt && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      stop_with_error("timeout while waiting for the core to halt");
    end else begin
      for (int i = 0; i < 20; i++) begin
        @(negedge clk);
        check_val("halt", 32'(halt), 32'd1);
        check_val("retire_valid", 32'(retire_valid), 32'd0);
        check_val("pc", pc, ref_pc);
      end
      if (!ref_halt) begin
        stop_with_error("core halted before the program reached its halting instruction");
      end
      check_val("illegal", 32'(illegal), 32'(exp_illegal));
    end
  endtask

  // compare every retire against the reference model
  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      if (ref_halt) begin
        stop_with_error("an instruction retired after the halting instruction");
      end else begin
        exp_ret = ref_step(imem[ref_pc[9:2]]);
        check_val("retire.pc", retire.pc, exp_ret.pc);
        check_val("retire.reg_write", 32'(retire.reg_write), 32'(exp_ret.reg_write));
        if (exp_ret.reg_write) begin
          check_val("retire.rd", 32'(retire.rd), 32'(exp_ret.rd));
          check_val("retire.wdata", retire.wdata, exp_ret.wdata);
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    lfsr_state = 32'hc36bec0d;
    gen_program(-1);
    apply_reset();
    run_to_halt(1'b0);

    // second run with an illegal word mid-program
    gen_program(PROG_LEN / 2);
    @(posedge clk);
    #1;
    apply_reset();
    run_to_halt(1'b1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
